// File: Makefile
# Verilator flow for the configuration control unit
TB_TOP = isaCfgUnit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f isaCfgUnit.f --top-module isaCfgUnit
	verilator --lint-only --timing --assert -f isaCfgUnit.f --top-module $(TB_TOP)

# The simulator exits with a failing status on $fatal or a failed assertion
sim:
	verilator --binary --timing --assert -j 0 -f isaCfgUnit.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o Vsim
	./obj_dir/Vsim

clean:
	rm -rf obj_dir

// File: include/isa_cfg_macros.svh
// Widths and counts shared by all RTL; HDR_ID_W must exceed ENG_ID_W and CREDIT_W must hold CREDIT_INIT
`ifndef ISA_CFG_MACROS_SVH
`define ISA_CFG_MACROS_SVH

// ==========================================================================
// Instruction stream
// ==========================================================================
`define ISA_WORD_W 32
`define CFG_WORDS 4

// ==========================================================================
// Engines and header target field
// ==========================================================================
`define NUM_ENGINES 4
`define ENG_ID_W 2
`define HDR_ID_W 3

// Credit flow toward the engines
`define CREDIT_INIT 2
`define CREDIT_W 2

`endif

// File: isaCfgUnit.f
+incdir+include
source/isaCfgPkg.sv
source/isaDecoder.sv
source/cfgAssembler.sv
source/cfgIssueArbiter.sv
source/isaCfgUnit.sv
tb/clockGen.sv
tb/isaCfgUnit_assertions.sv
tb/isaCfgUnit_tb.sv

// File: source/cfgAssembler.sv
// One engine channel; the engine must never return more credits than it received
`include "isa_cfg_macros.svh"

module cfgAssembler (
    input  logic                 clk,
    input  logic                 rst_n,
    input  isaCfgPkg::isaWord_t  wordDat,
    input  logic                 wordVld,
    output logic                 wordRdy,
    output logic                 reqVld,
    output isaCfgPkg::cfgInfo_t  reqInfo,
    input  logic                 grant,
    input  logic                 cfgCredit
);

    localparam int IDX_W = $clog2(`CFG_WORDS);

    logic [IDX_W-1:0]     wordIdx;
    logic                 full;
    logic [`CREDIT_W-1:0] credit;
    logic                 wordTake;
    logic                 hasCredit;
    isaCfgPkg::cfgInfo_t  info;

    assign wordTake  = wordVld & wordRdy;
    assign hasCredit = (credit != '0);

    // ======================================================================
    // Payload collection
    // ======================================================================

    // Shifting in from the top leaves word 0 in the low bits
    always_ff @(posedge clk) begin
        if (wordTake) begin
            info <= {wordDat, info[`CFG_WORDS*`ISA_WORD_W-1:`ISA_WORD_W]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wordIdx <= '0;
            full    <= 1'b0;
        end else begin
            if (wordTake) begin
                if (wordIdx == IDX_W'(`CFG_WORDS - 1)) begin
                    wordIdx <= '0;
                    full    <= 1'b1;
                end else begin
                    wordIdx <= wordIdx + 1'b1;
                end
            end else if (grant) begin
                full <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Credit counter
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= `CREDIT_W'(`CREDIT_INIT);
        end else begin
            case ({cfgCredit, grant})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    // No new words while a configuration waits
    assign wordRdy = ~full;
    assign reqVld  = full & hasCredit;
    assign reqInfo = info;

endmodule

// File: source/cfgIssueArbiter.sv
// Round-robin issue; at most one configuration per cycle on the registered shared bus
`include "isa_cfg_macros.svh"

module cfgIssueArbiter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`NUM_ENGINES-1:0]  reqVld,
    input  isaCfgPkg::cfgInfo_t      reqInfo [`NUM_ENGINES],
    output logic [`NUM_ENGINES-1:0]  grant,
    output logic                     cfgVld,
    output isaCfgPkg::engId_t        cfgDst,
    output isaCfgPkg::cfgInfo_t      cfgInfo
);

    isaCfgPkg::engId_t lastGnt;
    isaCfgPkg::engId_t winner;
    logic              found;

    // ======================================================================
    // Winner search
    // ======================================================================

    // Start one past the last granted channel
    always_comb begin
        int cand;
        found  = 1'b0;
        winner = lastGnt;
        cand   = 0;
        for (int i = 1; i <= `NUM_ENGINES; i++) begin
            cand = (int'(lastGnt) + i) % `NUM_ENGINES;
            if (!found && reqVld[cand]) begin
                found  = 1'b1;
                winner = `ENG_ID_W'(cand);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[winner] = 1'b1;
        end
    end

    // ======================================================================
    // Pointer and bus registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Channel 0 gets the first look
            lastGnt <= `ENG_ID_W'(`NUM_ENGINES - 1);
            cfgVld  <= 1'b0;
        end else begin
            cfgVld <= found;
            if (found) begin
                lastGnt <= winner;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            cfgDst  <= winner;
            cfgInfo <= reqInfo[winner];
        end
    end

endmodule

// File: source/isaCfgPkg.sv
// Shared types; all engines use one configuration width of CFG_WORDS instruction words
`include "isa_cfg_macros.svh"

package isaCfgPkg;

    // ======================================================================
    // Data types
    // ======================================================================

    // One word of the instruction stream
    typedef logic [`ISA_WORD_W-1:0] isaWord_t;

    // Assembled configuration, payload word 0 in the low bits
    typedef logic [`CFG_WORDS*`ISA_WORD_W-1:0] cfgInfo_t;

    // Engine and channel number
    typedef logic [`ENG_ID_W-1:0] engId_t;

    // ======================================================================
    // Decoder states
    // ======================================================================
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        DROP = 2'd2
    } decState_e;

endpackage

// File: source/isaCfgUnit.sv
// Top level; cfgCredit pulses return one credit each and cfgVld lasts one cycle per configuration
`include "isa_cfg_macros.svh"

module isaCfgUnit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  isaCfgPkg::isaWord_t      isaDat,
    input  logic                     isaVld,
    output logic                     isaRdy,
    input  logic [`NUM_ENGINES-1:0]  cfgCredit,
    output logic                     cfgVld,
    output isaCfgPkg::engId_t        cfgDst,
    output isaCfgPkg::cfgInfo_t      cfgInfo
);

    // ======================================================================
    // Internal wiring
    // ======================================================================
    isaCfgPkg::isaWord_t     wordDat;
    logic [`NUM_ENGINES-1:0] wordVld;
    logic [`NUM_ENGINES-1:0] wordRdy;
    logic [`NUM_ENGINES-1:0] reqVld;
    logic [`NUM_ENGINES-1:0] grant;
    isaCfgPkg::cfgInfo_t     reqInfo [`NUM_ENGINES];

    // Header decode and payload steering
    isaDecoder i_isaDecoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .isaDat  (isaDat),
        .isaVld  (isaVld),
        .isaRdy  (isaRdy),
        .wordDat (wordDat),
        .wordVld (wordVld),
        .wordRdy (wordRdy)
    );

    // ======================================================================
    // One assembler per engine
    // ======================================================================
    for (genvar g = 0; g < `NUM_ENGINES; g++) begin : gen_channel
        cfgAssembler i_cfgAssembler (
            .clk       (clk),
            .rst_n     (rst_n),
            .wordDat   (wordDat),
            .wordVld   (wordVld[g]),
            .wordRdy   (wordRdy[g]),
            .reqVld    (reqVld[g]),
            .reqInfo   (reqInfo[g]),
            .grant     (grant[g]),
            .cfgCredit (cfgCredit[g])
        );
    end

    // Shared configuration bus
    cfgIssueArbiter i_cfgIssueArbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .reqVld  (reqVld),
        .reqInfo (reqInfo),
        .grant   (grant),
        .cfgVld  (cfgVld),
        .cfgDst  (cfgDst),
        .cfgInfo (cfgInfo)
    );

endmodule

// File: source/isaDecoder.sv
// Expects one header and then exactly CFG_WORDS payload words; targets at or above NUM_ENGINES are discarded
`include "isa_cfg_macros.svh"

module isaDecoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  isaCfgPkg::isaWord_t      isaDat,
    input  logic                     isaVld,
    output logic                     isaRdy,
    output isaCfgPkg::isaWord_t      wordDat,
    output logic [`NUM_ENGINES-1:0]  wordVld,
    input  logic [`NUM_ENGINES-1:0]  wordRdy
);

    localparam int CNT_W = $clog2(`CFG_WORDS);

    isaCfgPkg::decState_e state;
    isaCfgPkg::decState_e nextState;
    isaCfgPkg::engId_t    target;
    logic [CNT_W-1:0]     wordCnt;
    logic [`HDR_ID_W-1:0] hdrId;
    logic                 hdrValid;
    logic                 take;
    logic                 lastWord;

    // ======================================================================
    // Header decode
    // ======================================================================
    assign hdrId    = isaDat[`HDR_ID_W-1:0];
    assign hdrValid = (hdrId < `HDR_ID_W'(`NUM_ENGINES));
    assign take     = isaVld & isaRdy;
    assign lastWord = (wordCnt == CNT_W'(`CFG_WORDS - 1));

    // ======================================================================
    // FSM
    // ======================================================================
    always_comb begin
        nextState = state;
        case (state)
            isaCfgPkg::IDLE: begin
                if (take) begin
                    nextState = hdrValid ? isaCfgPkg::LOAD : isaCfgPkg::DROP;
                end
            end
            isaCfgPkg::LOAD, isaCfgPkg::DROP: begin
                // Back to IDLE with the last payload word
                if (take && lastWord) begin
                    nextState = isaCfgPkg::IDLE;
                end
            end
            default: nextState = isaCfgPkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= isaCfgPkg::IDLE;
            target  <= '0;
            wordCnt <= '0;
        end else begin
            state <= nextState;
            if (state == isaCfgPkg::IDLE) begin
                if (take) begin
                    target  <= hdrId[`ENG_ID_W-1:0];
                    wordCnt <= '0;
                end
            end else if (take) begin
                wordCnt <= lastWord ? '0 : wordCnt + 1'b1;
            end
        end
    end

    // ======================================================================
    // Routing to channels
    // ======================================================================
    assign wordDat = isaDat;

    always_comb begin
        wordVld = '0;
        if (state == isaCfgPkg::LOAD) begin
            wordVld[target] = isaVld;
        end
    end

    // Stall only while the selected channel is full
    always_comb begin
        case (state)
            isaCfgPkg::LOAD: isaRdy = wordRdy[target];
            default:         isaRdy = 1'b1;
        endcase
    end

endmodule

// File: tb/clockGen.sv
// Free-running testbench clock, period 4 time units, starts low at time 0
module clockGen (
    output logic clk
);

    // Half period of 2 time units
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// File: tb/isaCfgUnit_assertions.sv
// Bound into cfgIssueArbiter; checks grant and bus sanity on rising clock edges only
`include "isa_cfg_macros.svh"

module isaCfgUnit_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic [`NUM_ENGINES-1:0]  reqVld,
    input logic [`NUM_ENGINES-1:0]  grant,
    input logic                     cfgVld,
    input isaCfgPkg::engId_t        cfgDst
);

    // ======================================================================
    // Arbitration
    // ======================================================================
    grantOneHot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("More than one grant in a cycle");

    // Grant only to a requesting channel
    grantHasReq: assert property (@(posedge clk) disable iff (!rst_n)
        ((grant & ~reqVld) == '0))
        else $error("Grant given to a channel without a request");

    // ======================================================================
    // Configuration bus
    // ======================================================================
    quietAfterReset: assert property (@(posedge clk)
        $rose(rst_n) |-> !cfgVld)
        else $error("Configuration bus valid in the first cycle after reset");

    // Destination must be an existing channel granted the cycle before
    dstInRange: assert property (@(posedge clk) disable iff (!rst_n)
        cfgVld |-> ($past(grant) == (`NUM_ENGINES'(1) << cfgDst)))
        else $error("Configuration sent to an engine out of range or not granted");

endmodule

// File: tb/isaCfgUnit_tb.sv
// Random messages from seed 68; stops at the first mismatch; engines return credits randomly
`include "isa_cfg_macros.svh"

module isaCfgUnit_tb;

    localparam int NUM_MSGS    = 300;
    localparam int STALL_LIMIT = 2000;
    localparam int DRAIN_LIMIT = 5000;

    logic                    clk;
    logic                    rst_n;
    isaCfgPkg::isaWord_t     isaDat;
    logic                    isaVld;
    logic                    isaRdy;
    logic [`NUM_ENGINES-1:0] cfgCredit = '0;
    logic                    cfgVld;
    isaCfgPkg::engId_t       cfgDst;
    isaCfgPkg::cfgInfo_t     cfgInfo;

    integer seed = 68;
    integer creditSeed;

    // Expected configurations and credits in use, per engine
    isaCfgPkg::cfgInfo_t expQ [`NUM_ENGINES][$];
    int outstanding [`NUM_ENGINES] = '{default: 0};
    int holdCnt [`NUM_ENGINES] = '{default: 0};

    clockGen i_clockGen (.clk(clk));

    isaCfgUnit i_isaCfgUnit (
        .clk       (clk),
        .rst_n     (rst_n),
        .isaDat    (isaDat),
        .isaVld    (isaVld),
        .isaRdy    (isaRdy),
        .cfgCredit (cfgCredit),
        .cfgVld    (cfgVld),
        .cfgDst    (cfgDst),
        .cfgInfo   (cfgInfo)
    );

    bind cfgIssueArbiter isaCfgUnit_assertions i_isaCfgUnit_assertions (
        .clk    (clk),
        .rst_n  (rst_n),
        .reqVld (reqVld),
        .grant  (grant),
        .cfgVld (cfgVld),
        .cfgDst (cfgDst)
    );

    // ======================================================================
    // Reporting
    // ======================================================================
    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compareValues(input string testName, input isaCfgPkg::cfgInfo_t expVal,
                                 input isaCfgPkg::cfgInfo_t actVal);
        if (expVal !== actVal) begin
            $display("[FAIL] %s expected %0h actual %0h", testName, expVal, actVal);
            abortRun("Value mismatch");
        end
    endtask

    function automatic int pendingCount();
        int total;
        total = 0;
        for (int e = 0; e < `NUM_ENGINES; e++) begin
            total += expQ[e].size();
        end
        return total;
    endfunction

    // One word on the instruction input, held until isaRdy takes it
    task automatic sendWord(input isaCfgPkg::isaWord_t word);
        int gap;
        int waitCnt;
        logic accepted;
        gap = $random(seed) & 7;
        if (gap > 2) begin
            gap = 0;
        end
        isaVld = 1'b0;
        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
        end
        isaDat  = word;
        isaVld  = 1'b1;
        waitCnt = 0;
        do begin
            #1 accepted = isaRdy;
            @(negedge clk);
            waitCnt++;
            if (waitCnt > STALL_LIMIT) begin
                abortRun("Instruction input stalled too long waiting for isaRdy");
            end
        end while (!accepted);
        isaVld = 1'b0;
    endtask

    // ======================================================================
    // Engine model and scoreboard
    // ======================================================================
    always @(negedge clk) begin : scoreboard
        int dst;
        isaCfgPkg::cfgInfo_t expInfo;
        if (rst_n) begin
            if (cfgVld) begin
                dst = int'(cfgDst);
                if (expQ[dst].size() == 0) begin
                    abortRun("Configuration issued to an engine with nothing pending");
                end
                expInfo = expQ[dst].pop_front();
                compareValues("cfgInfo", expInfo, cfgInfo);
                outstanding[dst]++;
                if (outstanding[dst] > `CREDIT_INIT) begin
                    abortRun("Engine received more configurations than it has credits");
                end
            end
            // Credit pulses, with occasional long holds per engine
            for (int e = 0; e < `NUM_ENGINES; e++) begin
                cfgCredit[e] = 1'b0;
                if (holdCnt[e] > 0) begin
                    holdCnt[e]--;
                end else if (($random(creditSeed) & 63) == 0) begin
                    holdCnt[e] = 20 + ($random(creditSeed) & 31);
                end else if (outstanding[e] > 0 && ($random(creditSeed) & 3) == 0) begin
                    cfgCredit[e] = 1'b1;
                    outstanding[e]--;
                end
            end
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin : stimulus
        isaCfgPkg::isaWord_t hdr;
        isaCfgPkg::isaWord_t words [`CFG_WORDS];
        isaCfgPkg::cfgInfo_t info;
        int tgt;
        int waitCnt;
        rst_n      = 1'b0;
        isaVld     = 1'b0;
        isaDat     = '0;
        creditSeed = $random(seed);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        #1;
        compareValues("reset cfgVld", isaCfgPkg::cfgInfo_t'(1'b0), isaCfgPkg::cfgInfo_t'(cfgVld));
        compareValues("reset isaRdy", isaCfgPkg::cfgInfo_t'(1'b1), isaCfgPkg::cfgInfo_t'(isaRdy));
        @(negedge clk);

        for (int m = 0; m < NUM_MSGS; m++) begin
            hdr  = $random(seed);
            tgt  = int'(hdr[`HDR_ID_W-1:0]);
            info = '0;
            for (int w = 0; w < `CFG_WORDS; w++) begin
                words[w] = $random(seed);
                info[w*`ISA_WORD_W +: `ISA_WORD_W] = words[w];
            end
            // Targets 4 to 7 are dropped and expect no output
            if (tgt < `NUM_ENGINES) begin
                expQ[tgt].push_back(info);
            end
            sendWord(hdr);
            for (int w = 0; w < `CFG_WORDS; w++) begin
                sendWord(words[w]);
            end
        end

        waitCnt = 0;
        while (pendingCount() != 0) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > DRAIN_LIMIT) begin
                abortRun("Expected configurations did not drain before the timeout");
            end
        end
        // Catch late spurious issues
        repeat (20) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule
